// File: Bender.yml
package:
  name: manycore_mem_sys

sources:
  - files:
      - verilog/mem_cfg_pkg.sv
      - verilog/dma_pkg.sv
      - verilog/dma_req_if.sv
      - verilog/dma_fifo.sv
      - verilog/vcache_dma_port.sv
      - verilog/dma_rr_arbiter.sv
      - verilog/test_dram.sv
      - verilog/manycore_mem_sys.sv
  - target: test
    files:
      - testbench/mem_sys_checker.sv
      - testbench/tb_manycore_mem_sys.sv

// File: files.f
verilog/mem_cfg_pkg.sv
verilog/dma_pkg.sv
verilog/dma_req_if.sv
verilog/dma_fifo.sv
verilog/vcache_dma_port.sv
verilog/dma_rr_arbiter.sv
verilog/test_dram.sv
verilog/manycore_mem_sys.sv
testbench/mem_sys_checker.sv
testbench/tb_manycore_mem_sys.sv

// File: testbench/mem_sys_checker.sv
// checker for the vcache memory system
// per-port expected read data, in-order compare, error counts

`timescale 1ns/1ps

module mem_sys_checker (
  input  logic                                           clk_i,
  input  logic                                           arst_n_i,
  input  logic [mem_cfg_pkg::NUM_VCACHES-1:0]             data_v_i,
  input  dma_pkg::data_t [mem_cfg_pkg::NUM_VCACHES-1:0]   data_i,
  input  logic [mem_cfg_pkg::NUM_VCACHES-1:0]             data_yumi_i
);

  localparam int n_lp     = mem_cfg_pkg::NUM_VCACHES;
  localparam int slots_lp = 16;

  dma_pkg::data_t exp_mem [n_lp][slots_lp];
  int             exp_head [n_lp];
  int             exp_tail [n_lp];
  int             mismatch_count;
  int             fail_count;

  initial begin
    for (int p = 0; p < n_lp; p++) begin
      exp_head[p] = 0;
      exp_tail[p] = 0;
    end
    mismatch_count = 0;
    fail_count     = 0;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    fail_count++;
  endtask

  // one expected word per accepted read
  task automatic push_expected(input int port, input dma_pkg::data_t word);
    if (exp_tail[port] - exp_head[port] >= slots_lp) begin
      report_failure($sformatf("port %0d has too many reads outstanding", port));
    end else begin
      exp_mem[port][exp_tail[port] % slots_lp] = word;
      exp_tail[port]++;
    end
  endtask

  function automatic int pending_words();
    int total;
    total = 0;
    for (int p = 0; p < n_lp; p++) begin
      total += exp_tail[p] - exp_head[p];
    end
    return total;
  endfunction

  task automatic report_missing();
    for (int p = 0; p < n_lp; p++) begin
      if (exp_tail[p] != exp_head[p]) begin
        report_failure($sformatf("port %0d is missing %0d read responses",
                                 p, exp_tail[p] - exp_head[p]));
      end
    end
  endtask

  // compare on every data transfer
  always @(posedge clk_i) begin : compare
    dma_pkg::data_t exp_word;
    if (arst_n_i) begin
      for (int p = 0; p < n_lp; p++) begin
        if (data_v_i[p] && data_yumi_i[p]) begin
          if (exp_tail[p] == exp_head[p]) begin
            report_failure($sformatf("port %0d returned a word with no read outstanding", p));
          end else begin
            exp_word = exp_mem[p][exp_head[p] % slots_lp];
            if (data_i[p] !== exp_word) begin
              $display("MISMATCH dma_data_o[%0d] expected %h actual %h", p, exp_word, data_i[p]);
              mismatch_count++;
            end
            exp_head[p]++;
          end
        end
      end
    end
  end

endmodule

// File: testbench/mem_sys_stimulus.txt
# vcache DMA stimulus, one request per line
# columns: port (decimal), op W or R, local address (hex), data (hex, write value or expected read)
# single port, write then read back
0 W 10 a5a50010
0 R 10 a5a50010
# same local address on every port, each id keeps its own word
0 W 40 c0de0040
1 W 40 c1de0040
2 W 40 c2de0040
3 W 40 c3de0040
0 R 40 c0de0040
1 R 40 c1de0040
2 R 40 c2de0040
3 R 40 c3de0040
# mixed traffic on all ports
1 W 20 1111aaaa
2 W 21 2222bbbb
3 W 22 3333cccc
0 W 23 0000dddd
1 R 20 1111aaaa
2 R 21 2222bbbb
0 R 23 0000dddd
3 R 22 3333cccc
1 W 20 1111eeee
1 R 20 1111eeee
2 W 05 22220505
2 R 05 22220505
0 R 10 a5a50010
1 R 40 c1de0040
2 R 40 c2de0040
0 W 7f 00007f7f
0 R 7f 00007f7f
# port 3 ends with a run of reads while its data path is held
3 R 40 c3de0040
3 R 22 3333cccc
3 R 40 c3de0040
3 R 22 3333cccc
3 R 40 c3de0040
3 R 22 3333cccc
3 R 40 c3de0040
3 R 22 3333cccc

// File: testbench/tb_manycore_mem_sys.sv
// testbench for manycore_mem_sys
// clock and reset, per-port request drivers fed from the stimulus file,
// throttled read data, one stalled data path, closing report

`timescale 1ns/1ps

module tb_manycore_mem_sys;

  localparam int          n_lp            = mem_cfg_pkg::NUM_VCACHES;
  localparam int          max_lines_lp    = 64;
  localparam logic [31:0] seed_lp         = 32'h2753_7f99;
  localparam int          stall_port_lp   = 3;
  localparam int          stall_cycles_lp = 40;
  // reads left on the stall port when its data path gets blocked
  localparam int          stall_tail_lp   = 8;
  localparam int          start_limit_lp  = 100;
  localparam int          accept_limit_lp = 200;
  localparam int          run_limit_lp    = 4000;

  logic                                clk;
  logic                                arst_n;
  logic [n_lp-1:0]                     dma_pkt_v;
  dma_pkg::dma_pkt_s [n_lp-1:0]        dma_pkt;
  logic [n_lp-1:0]                     dma_pkt_yumi;
  logic [n_lp-1:0]                     dma_data_v;
  dma_pkg::data_t [n_lp-1:0]           dma_data;
  logic [n_lp-1:0]                     dma_data_yumi;
  logic [n_lp-1:0]                     drv_done;
  logic                                start_traffic;
  logic                                stall_on;

  // stimulus lines
  int          line_port [max_lines_lp];
  logic [7:0]  line_op   [max_lines_lp];
  logic [7:0]  line_addr [max_lines_lp];
  logic [31:0] line_data [max_lines_lp];
  int          n_lines;
  int          port_lines [n_lp];

  always #5 clk = ~clk;

  manycore_mem_sys u_dut (
    .clk_i           (clk),
    .arst_n_i        (arst_n),
    .dma_pkt_v_i     (dma_pkt_v),
    .dma_pkt_i       (dma_pkt),
    .dma_pkt_yumi_o  (dma_pkt_yumi),
    .dma_data_v_o    (dma_data_v),
    .dma_data_o      (dma_data),
    .dma_data_yumi_i (dma_data_yumi)
  );

  mem_sys_checker u_chk (
    .clk_i       (clk),
    .arst_n_i    (arst_n),
    .data_v_i    (dma_data_v),
    .data_i      (dma_data),
    .data_yumi_i (dma_data_yumi)
  );

  for (genvar g = 0; g < n_lp; g++) begin : g_drv
    logic              v_r    = 1'b0;
    dma_pkg::dma_pkt_s pkt_r  = '0;
    logic              yumi_r = 1'b0;
    logic              done_r = 1'b0;
    int                sent_r = 0;
    integer            gap_seed  = seed_lp + g;
    integer            yumi_seed = seed_lp + 16 + g;

    assign dma_pkt_v[g]     = v_r;
    assign dma_pkt[g]       = pkt_r;
    assign dma_data_yumi[g] = yumi_r;
    assign drv_done[g]      = done_r;

    // requests of this port in file order, random idle gaps
    initial begin : drive
      int gap;
      int wait_cyc;
      wait_cyc = 0;
      while (start_traffic !== 1'b1 && wait_cyc < start_limit_lp) begin
        @(negedge clk);
        wait_cyc++;
      end
      if (start_traffic !== 1'b1) begin
        u_chk.report_failure($sformatf("port %0d driver never saw traffic start", g));
      end
      for (int n = 0; n < n_lines; n++) begin
        if (line_port[n] == g) begin
          gap = $random(gap_seed) & 3;
          repeat (gap) @(negedge clk);
          pkt_r.write_not_read = (line_op[n] == "W");
          pkt_r.addr           = line_addr[n];
          pkt_r.data           = (line_op[n] == "W") ? line_data[n] : '0;
          v_r                  = 1'b1;
          #1;
          wait_cyc = 0;
          while (!dma_pkt_yumi[g] && wait_cyc < accept_limit_lp) begin
            @(negedge clk);
            #1;
            wait_cyc++;
          end
          if (dma_pkt_yumi[g]) begin
            if (line_op[n] == "R") begin
              u_chk.push_expected(g, line_data[n]);
            end
            sent_r++;
          end else begin
            u_chk.report_failure($sformatf("port %0d request on stimulus line %0d was not accepted",
                                           g, n));
          end
          @(negedge clk);
          v_r = 1'b0;
        end
      end
      done_r = 1'b1;
    end

    // take read data only while valid, randomly throttled
    always @(negedge clk) begin
      if (stall_on && g == stall_port_lp) begin
        yumi_r = 1'b0;
      end else begin
        yumi_r = dma_data_v[g] && (($random(yumi_seed) & 3) != 0);
      end
    end
  end

  // port, W or R, local address and data on each line, # lines are comments
  task automatic load_stimulus();
    integer             fd;
    integer             got;
    reg [8*128-1:0]     line_buf;
    int                 port;
    logic [7:0]         op;
    logic [7:0]         addr;
    logic [31:0]        data;
    n_lines = 0;
    for (int p = 0; p < n_lp; p++) begin
      port_lines[p] = 0;
    end
    fd = $fopen("testbench/mem_sys_stimulus.txt", "r");
    if (fd == 0) begin
      u_chk.report_failure("could not open the stimulus file");
    end else begin
      while (!$feof(fd)) begin
        line_buf = '0;
        got = $fgets(line_buf, fd);
        if (got > 0 && $sscanf(line_buf, "%d %c %h %h", port, op, addr, data) == 4) begin
          if (port < 0 || port >= n_lp || n_lines >= max_lines_lp || (op != "W" && op != "R")) begin
            u_chk.report_failure($sformatf("stimulus line %0d could not be used", n_lines));
          end else begin
            line_port[n_lines] = port;
            line_op[n_lines]   = op;
            line_addr[n_lines] = addr;
            line_data[n_lines] = data;
            port_lines[port]++;
            n_lines++;
          end
        end
      end
      $fclose(fd);
    end
    if (n_lines == 0) begin
      u_chk.report_failure("the stimulus file holds no requests");
    end
  endtask

  task automatic check_idle_after_reset();
    repeat (5) begin
      @(negedge clk);
      #1;
      if (dma_pkt_yumi !== '0 || dma_data_v !== '0) begin
        u_chk.report_failure("request yumi or data valid went high with no stimulus");
      end
    end
  endtask

  // hold read data on one port while it keeps sending reads
  task automatic run_stall_window();
    int   cyc;
    logic saw_block;
    cyc       = 0;
    saw_block = 1'b0;
    while (g_drv[stall_port_lp].sent_r < port_lines[stall_port_lp] - stall_tail_lp
           && cyc < run_limit_lp) begin
      @(negedge clk);
      #1;
      cyc++;
    end
    if (cyc >= run_limit_lp) begin
      u_chk.report_failure("the stalled port never reached its run of reads");
    end else begin
      stall_on = 1'b1;
      repeat (stall_cycles_lp) begin
        @(negedge clk);
        #1;
        if (dma_pkt_v[stall_port_lp] && !dma_pkt_yumi[stall_port_lp]) begin
          saw_block = 1'b1;
        end
      end
      stall_on = 1'b0;
      if (!saw_block) begin
        u_chk.report_failure($sformatf("port %0d kept accepting requests while its data was held",
                                       stall_port_lp));
      end
    end
  endtask

  task automatic wait_drivers_done();
    int cyc;
    cyc = 0;
    while (drv_done != '1 && cyc < run_limit_lp) begin
      @(negedge clk);
      cyc++;
    end
    if (drv_done != '1) begin
      u_chk.report_failure("request drivers did not finish in time");
    end
  endtask

  task automatic wait_responses();
    int cyc;
    cyc = 0;
    while (u_chk.pending_words() != 0 && cyc < accept_limit_lp) begin
      @(negedge clk);
      cyc++;
    end
    // a late duplicate word would show up here
    repeat (2 * mem_cfg_pkg::DRAM_LAT + 4) @(negedge clk);
    u_chk.report_missing();
  endtask

  initial begin : main
    clk           = 1'b0;
    arst_n        = 1'b0;
    start_traffic = 1'b0;
    stall_on      = 1'b0;
    load_stimulus();
    repeat (8) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    check_idle_after_reset();
    start_traffic = 1'b1;
    fork
      run_stall_window();
      wait_drivers_done();
    join
    wait_responses();
    $display("errors: %0d mismatches, %0d other failures",
             u_chk.mismatch_count, u_chk.fail_count);
    if (u_chk.mismatch_count == 0 && u_chk.fail_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin : watchdog
    #200000;
    $display("simulation ran past its time limit");
    $display("Errors found");
    $finish;
  end

endmodule

// File: verilog/dma_fifo.sv
// small circular-buffer FIFO, element type given as a parameter
// valid/yumi on the output side, occupancy count for credit checks

`timescale 1ns/1ps

module dma_fifo #(
  parameter type el_t    = logic,
  parameter int  depth_p = 2
) (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  input  logic                         v_i,
  input  el_t                          data_i,
  output logic                         ready_o,
  output logic                         v_o,
  output el_t                          data_o,
  input  logic                         yumi_i,
  output logic [$clog2(depth_p+1)-1:0] count_o
);

  localparam int ptr_w_lp = (depth_p > 1) ? $clog2(depth_p) : 1;
  localparam int cnt_w_lp = $clog2(depth_p + 1);

  el_t                 mem_r [depth_p];
  logic [ptr_w_lp-1:0] wr_ptr_r;
  logic [ptr_w_lp-1:0] rd_ptr_r;
  logic [cnt_w_lp-1:0] count_r;
  logic                enq;
  logic                deq;

  // pointer step with wrap for any depth
  function automatic logic [ptr_w_lp-1:0] ptr_inc(input logic [ptr_w_lp-1:0] ptr);
    if (int'(ptr) == depth_p - 1) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign ready_o = (count_r < depth_p);
  assign v_o     = (count_r != '0);
  assign data_o  = mem_r[rd_ptr_r];
  assign count_o = count_r;

  assign enq = v_i & ready_o;
  assign deq = yumi_i & v_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (enq) begin
        wr_ptr_r <= ptr_inc(wr_ptr_r);
      end
      if (deq) begin
        rd_ptr_r <= ptr_inc(rd_ptr_r);
      end
      case ({enq, deq})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (enq) begin
      mem_r[wr_ptr_r] <= data_i;
    end
  end

endmodule

// File: verilog/dma_pkg.sv
// DMA packet as seen at a vcache port
// memory word address with port id, data word type

package dma_pkg;

  // one data word
  typedef logic [mem_cfg_pkg::DATA_W-1:0] data_t;

  // request packet from a vcache, 41 bits
  typedef struct packed {
    logic                                write_not_read;
    logic [mem_cfg_pkg::LOCAL_ADDR_W-1:0] addr;
    data_t                               data;
  } dma_pkt_s;

  // address in the shared memory
  // id in the upper bits so caches never alias
  typedef struct packed {
    logic [mem_cfg_pkg::VCACHE_ID_W-1:0]  id;
    logic [mem_cfg_pkg::LOCAL_ADDR_W-1:0] local_addr;
  } mem_addr_s;

endpackage

// File: verilog/dma_req_if.sv
// memory request link with valid/yumi handshake
// src holds v and payload until dst raises yumi

`timescale 1ns/1ps

interface dma_req_if;

  logic              v;
  logic              write_not_read;
  dma_pkg::mem_addr_s addr;
  dma_pkg::data_t    data;
  logic              yumi;

  modport src (
    output v, write_not_read, addr, data,
    input  yumi
  );

  modport dst (
    input  v, write_not_read, addr, data,
    output yumi
  );

endinterface

// File: verilog/dma_rr_arbiter.sv
// round-robin arbiter of vcache port requests onto one memory channel
// grant search starts after the last granted port

`timescale 1ns/1ps

module dma_rr_arbiter (
  input  logic   clk_i,
  input  logic   arst_n_i,
  dma_req_if.dst req [mem_cfg_pkg::NUM_VCACHES],
  dma_req_if.src mem
);

  localparam int n_lp = mem_cfg_pkg::NUM_VCACHES;

  typedef logic [mem_cfg_pkg::VCACHE_ID_W-1:0] id_t;

  logic [n_lp-1:0]                req_v;
  logic [n_lp-1:0]                req_wnr;
  dma_pkg::mem_addr_s [n_lp-1:0]  req_addr;
  dma_pkg::data_t [n_lp-1:0]      req_data;
  id_t                            last_r;
  id_t                            grant_id;
  logic                           grant_v;

  for (genvar i = 0; i < n_lp; i++) begin : g_port
    assign req_v[i]    = req[i].v;
    assign req_wnr[i]  = req[i].write_not_read;
    assign req_addr[i] = req[i].addr;
    assign req_data[i] = req[i].data;
    // only the granted port sees yumi
    assign req[i].yumi = mem.yumi & grant_v & (grant_id == id_t'(i));
  end

  // first requester after last_r, wrapping around
  always_comb begin
    int idx;
    grant_v  = 1'b0;
    grant_id = last_r;
    for (int k = 1; k <= n_lp; k++) begin
      idx = (int'(last_r) + k) % n_lp;
      if (!grant_v && req_v[idx]) begin
        grant_v  = 1'b1;
        grant_id = id_t'(idx);
      end
    end
  end

  assign mem.v              = grant_v;
  assign mem.write_not_read = req_wnr[grant_id];
  assign mem.addr           = req_addr[grant_id];
  assign mem.data           = req_data[grant_id];

  // port 0 goes first after reset
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      last_r <= id_t'(n_lp - 1);
    end else if (mem.v && mem.yumi) begin
      last_r <= grant_id;
    end
  end

endmodule

// File: verilog/manycore_mem_sys.sv
// memory side of the manycore: vcache DMA ports, round-robin arbiter,
// shared test DRAM on a single channel

`timescale 1ns/1ps

module manycore_mem_sys (
  input  logic                                            clk_i,
  input  logic                                            arst_n_i,

  // request side, one entry per vcache
  input  logic [mem_cfg_pkg::NUM_VCACHES-1:0]              dma_pkt_v_i,
  input  dma_pkg::dma_pkt_s [mem_cfg_pkg::NUM_VCACHES-1:0] dma_pkt_i,
  output logic [mem_cfg_pkg::NUM_VCACHES-1:0]              dma_pkt_yumi_o,

  // read data back to each vcache
  output logic [mem_cfg_pkg::NUM_VCACHES-1:0]              dma_data_v_o,
  output dma_pkg::data_t [mem_cfg_pkg::NUM_VCACHES-1:0]    dma_data_o,
  input  logic [mem_cfg_pkg::NUM_VCACHES-1:0]              dma_data_yumi_i
);

  logic                                resp_v;
  logic [mem_cfg_pkg::VCACHE_ID_W-1:0] resp_id;
  dma_pkg::data_t                      resp_data;

  dma_req_if port_req [mem_cfg_pkg::NUM_VCACHES] ();
  dma_req_if mem_req ();

  for (genvar i = 0; i < mem_cfg_pkg::NUM_VCACHES; i++) begin : g_vc
    vcache_dma_port #(
      .port_id_p (i)
    ) u_port (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .pkt_v_i     (dma_pkt_v_i[i]),
      .pkt_i       (dma_pkt_i[i]),
      .pkt_yumi_o  (dma_pkt_yumi_o[i]),
      .data_v_o    (dma_data_v_o[i]),
      .data_o      (dma_data_o[i]),
      .data_yumi_i (dma_data_yumi_i[i]),
      .req         (port_req[i]),
      .resp_v_i    (resp_v),
      .resp_id_i   (resp_id),
      .resp_data_i (resp_data)
    );
  end

  dma_rr_arbiter u_arb (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .req      (port_req),
    .mem      (mem_req)
  );

  // responses go to every port, each one filters by id
  test_dram u_dram (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req         (mem_req),
    .resp_v_o    (resp_v),
    .resp_id_o   (resp_id),
    .resp_data_o (resp_data)
  );

endmodule

// File: verilog/mem_cfg_pkg.sv
// sizing constants of the vcache memory system
// port count, address and data widths, DRAM latency, queue depth

package mem_cfg_pkg;

  // peer vcache DMA ports sharing one channel
  localparam int NUM_VCACHES = 4;

  // port id, placed in front of the local word address
  localparam int VCACHE_ID_W = 2;

  // cache-local word address
  localparam int LOCAL_ADDR_W = 8;

  // full word address in the shared test DRAM
  localparam int MEM_ADDR_W = VCACHE_ID_W + LOCAL_ADDR_W;

  // one data word per request
  localparam int DATA_W = 32;

  // cycles from request acceptance to read response
  localparam int DRAM_LAT = 3;

  // entries in each port's request and response queue
  localparam int PORT_FIFO_DEPTH = 2;

endpackage

// File: verilog/test_dram.sv
// test DRAM: word memory shared by all vcache ports
// fixed-latency read pipeline, response broadcast tagged with port id

`timescale 1ns/1ps

module test_dram (
  input  logic                                clk_i,
  input  logic                                arst_n_i,
  dma_req_if.dst                              req,
  output logic                                resp_v_o,
  output logic [mem_cfg_pkg::VCACHE_ID_W-1:0] resp_id_o,
  output dma_pkg::data_t                      resp_data_o
);

  localparam int lat_lp   = mem_cfg_pkg::DRAM_LAT;
  localparam int words_lp = 2 ** mem_cfg_pkg::MEM_ADDR_W;

  dma_pkg::data_t                                mem_r [words_lp];
  logic [lat_lp-1:0]                             pipe_v_r;
  logic [lat_lp-1:0][mem_cfg_pkg::VCACHE_ID_W-1:0] pipe_id_r;
  dma_pkg::data_t [lat_lp-1:0]                   pipe_data_r;
  logic                                          wr_accept;
  logic                                          rd_accept;

  // never stalls, takes whatever is offered
  assign req.yumi = req.v;

  assign wr_accept = req.v & req.yumi & req.write_not_read;
  assign rd_accept = req.v & req.yumi & ~req.write_not_read;

  // write lands at acceptance
  always_ff @(posedge clk_i) begin
    if (wr_accept) begin
      mem_r[req.addr] <= req.data;
    end
  end

  // read valid pipeline
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pipe_v_r <= '0;
    end else begin
      pipe_v_r[0] <= rd_accept;
      for (int s = 1; s < lat_lp; s++) begin
        pipe_v_r[s] <= pipe_v_r[s-1];
      end
    end
  end

  // id and data follow the valid bits
  // memory read at acceptance, one read can enter every cycle
  always_ff @(posedge clk_i) begin
    pipe_id_r[0]   <= req.addr.id;
    pipe_data_r[0] <= mem_r[req.addr];
    for (int s = 1; s < lat_lp; s++) begin
      pipe_id_r[s]   <= pipe_id_r[s-1];
      pipe_data_r[s] <= pipe_data_r[s-1];
    end
  end

  assign resp_v_o    = pipe_v_r[lat_lp-1];
  assign resp_id_o   = pipe_id_r[lat_lp-1];
  assign resp_data_o = pipe_data_r[lat_lp-1];

endmodule

// File: verilog/vcache_dma_port.sv
// one vcache DMA port: request queue, read credit, response queue
// prefixes its id to the local address, picks its own responses

`timescale 1ns/1ps

module vcache_dma_port #(
  parameter int port_id_p = 0
) (
  input  logic                                clk_i,
  input  logic                                arst_n_i,

  input  logic                                pkt_v_i,
  input  dma_pkg::dma_pkt_s                   pkt_i,
  output logic                                pkt_yumi_o,

  output logic                                data_v_o,
  output dma_pkg::data_t                      data_o,
  input  logic                                data_yumi_i,

  dma_req_if.src                              req,

  input  logic                                resp_v_i,
  input  logic [mem_cfg_pkg::VCACHE_ID_W-1:0] resp_id_i,
  input  dma_pkg::data_t                      resp_data_i
);

  localparam int depth_lp = mem_cfg_pkg::PORT_FIFO_DEPTH;
  localparam int cnt_w_lp = $clog2(depth_lp + 1);
  localparam logic [mem_cfg_pkg::VCACHE_ID_W-1:0] id_lp =
    port_id_p[mem_cfg_pkg::VCACHE_ID_W-1:0];

  logic              pkt_ready;
  logic              head_v;
  dma_pkg::dma_pkt_s head;
  logic              resp_hit;
  logic [cnt_w_lp-1:0] resp_count;
  logic [cnt_w_lp-1:0] inflight_r;
  logic [cnt_w_lp:0]   used_credits;
  logic              credit_ok;
  logic              rd_issue;

  // request queue, accepts in the same cycle as v
  dma_fifo #(
    .el_t    (dma_pkg::dma_pkt_s),
    .depth_p (depth_lp)
  ) u_req_fifo (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .v_i      (pkt_v_i),
    .data_i   (pkt_i),
    .ready_o  (pkt_ready),
    .v_o      (head_v),
    .data_o   (head),
    .yumi_i   (req.yumi),
    .count_o  ()
  );

  assign pkt_yumi_o = pkt_v_i & pkt_ready;

  // a read needs a response slot not already promised
  assign used_credits = resp_count + inflight_r;
  assign credit_ok    = (used_credits < depth_lp);

  assign req.v              = head_v & (head.write_not_read | credit_ok);
  assign req.write_not_read = head.write_not_read;
  assign req.addr           = '{id: id_lp, local_addr: head.addr};
  assign req.data           = head.data;

  assign rd_issue = req.v & req.yumi & ~head.write_not_read;
  assign resp_hit = resp_v_i & (resp_id_i == id_lp);

  // reads between acceptance in memory and the response
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      inflight_r <= '0;
    end else begin
      case ({rd_issue, resp_hit})
        2'b10:   inflight_r <= inflight_r + 1'b1;
        2'b01:   inflight_r <= inflight_r - 1'b1;
        default: inflight_r <= inflight_r;
      endcase
    end
  end

  // response queue, always has room thanks to the credit check
  dma_fifo #(
    .el_t    (dma_pkg::data_t),
    .depth_p (depth_lp)
  ) u_resp_fifo (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .v_i      (resp_hit),
    .data_i   (resp_data_i),
    .ready_o  (),
    .v_o      (data_v_o),
    .data_o   (data_o),
    .yumi_i   (data_yumi_i),
    .count_o  (resp_count)
  );

endmodule
